//--- design/gem_pkg.sv
package gem_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 13;

    // address bit 12 picks between the two 4 KiB pages
    localparam int PAGE_BIT = 12;

    // full-width INCR bursts only, so one beat is one data word
    localparam int BEAT_STEP = DATA_W / 8;

    localparam logic DATA_PAGE    = 1'b0;
    localparam logic CONTROL_PAGE = 1'b1;

    // offsets within a page
    localparam logic [PAGE_BIT-1:0] DATA_BASE    = '0;
    localparam logic [PAGE_BIT-1:0] DMA_DONE_REG = '0;

    // queue entry kinds
    localparam logic KIND_DATA  = 1'b0;
    localparam logic KIND_CLOSE = 1'b1;

    typedef logic [DATA_W-1:0] data_t;

    localparam data_t DMA_DONE_MASK = DATA_W'(1);

    // the same address word, seen flat for stepping or split for page decode
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic                page;
            logic [PAGE_BIT-1:0] offset;
        } paged;
    } gem_addr_u;

    typedef struct packed {
        logic  kind;
        logic  first;
        data_t data;
    } entry_t;

endpackage

//--- design/gem_write_slave.sv
module gem_write_slave import gem_pkg::*; #(
    parameter int ID_W = 2
) (
    input  logic            clk,
    input  logic            reset,

    input  logic [ID_W-1:0] i_awid,
    input  gem_addr_u       i_awaddr,
    input  logic [7:0]      i_awlen,
    input  logic            i_awvalid,
    output logic            o_awready,

    input  data_t           i_wdata,
    input  logic            i_wlast,
    input  logic            i_wvalid,
    output logic            o_wready,

    output logic [ID_W-1:0] o_bid,
    output logic [1:0]      o_bresp,
    output logic            o_bvalid,
    input  logic            i_bready,

    output logic            o_push_valid,
    output entry_t          o_push_entry,
    input  logic            i_push_ready
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRITE = 2'd1;
    localparam logic [1:0] ST_RESP  = 2'd2;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic [1:0]      r_state;
    logic [ID_W-1:0] r_id;
    gem_addr_u       r_addr;
    logic [7:0]      r_beats_left;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic last_beat;
    logic is_data;
    logic is_done;

    assign aw_fire = i_awvalid && o_awready;
    assign w_fire  = i_wvalid && o_wready;
    assign b_fire  = o_bvalid && i_bready;

    // wlast normally ends the burst, the beat count is a backstop
    assign last_beat = i_wlast || (r_beats_left == '0);

    // page decode of the current beat address
    assign is_data = r_addr.paged.page == DATA_PAGE;
    assign is_done = (r_addr.paged.page == CONTROL_PAGE)
                  && (r_addr.paged.offset == DMA_DONE_REG)
                  && |(i_wdata & DMA_DONE_MASK);

    assign o_awready = r_state == ST_IDLE;
    assign o_bvalid  = r_state == ST_RESP;
    assign o_bid     = r_id;
    assign o_bresp   = RESP_OKAY;

    // W is only taken when the queue has room, even for control beats
    assign o_wready = (r_state == ST_WRITE) && i_push_ready;

    // data beats and done writes go in, other control writes vanish here
    assign o_push_valid = (r_state == ST_WRITE) && i_wvalid && (is_data || is_done);

    always_comb begin
        o_push_entry.kind  = is_data ? KIND_DATA : KIND_CLOSE;
        o_push_entry.first = is_data && (r_addr.paged.offset == DATA_BASE);
        o_push_entry.data  = i_wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_state <= ST_IDLE;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (aw_fire) begin
                        r_state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (w_fire && last_beat) begin
                        r_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_fire) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: begin
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

    // burst context, captured on AW and walked one word per W beat
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            r_id         <= i_awid;
            r_addr       <= i_awaddr;
            r_beats_left <= i_awlen;
        end else if (w_fire) begin
            r_addr.flat  <= r_addr.flat + ADDR_W'(BEAT_STEP);
            r_beats_left <= r_beats_left - 8'd1;
        end
    end

endmodule

//--- design/gem_beat_queue.sv
module gem_beat_queue import gem_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic   clk,
    input  logic   reset,

    input  logic   i_push_valid,
    input  entry_t i_push_entry,
    output logic   o_push_ready,

    output logic   o_pop_valid,
    output entry_t o_pop_entry,
    input  logic   i_pop_ready
);

    localparam int PTR_W = $clog2(DEPTH);

    entry_t mem [DEPTH];

    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [PTR_W:0]   r_count;

    logic push_fire;
    logic pop_fire;

    assign o_push_ready = r_count != (PTR_W + 1)'(DEPTH);
    assign o_pop_valid  = r_count != '0;
    assign o_pop_entry  = mem[r_rd_ptr];

    assign push_fire = i_push_valid && o_push_ready;
    assign pop_fire  = o_pop_valid && i_pop_ready;

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (push_fire) begin
                r_wr_ptr <= r_wr_ptr + PTR_W'(1);
            end
            if (pop_fire) begin
                r_rd_ptr <= r_rd_ptr + PTR_W'(1);
            end
            case ({push_fire, pop_fire})
                2'b10:   r_count <= r_count + (PTR_W + 1)'(1);
                2'b01:   r_count <= r_count - (PTR_W + 1)'(1);
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[r_wr_ptr] <= i_push_entry;
        end
    end

endmodule

//--- design/gem_tlast_stage.sv
module gem_tlast_stage import gem_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    input  logic   i_pop_valid,
    input  entry_t i_pop_entry,
    output logic   o_pop_ready,

    output data_t  o_tdata,
    output logic   o_tlast,
    output logic   o_tvalid,
    input  logic   i_tready
);

    // the held beat waits until the next entry says whether it was last
    logic  r_held_valid;
    data_t r_held_data;

    // registered stream output slot
    logic  r_out_valid;
    data_t r_out_data;
    logic  r_out_last;

    logic out_free;
    logic pop_fire;
    logic pop_is_data;

    assign o_tvalid = r_out_valid;
    assign o_tdata  = r_out_data;
    assign o_tlast  = r_out_last;

    // slot is free now or drains on this edge
    assign out_free    = !r_out_valid || i_tready;
    assign o_pop_ready = out_free;

    assign pop_fire    = i_pop_valid && o_pop_ready;
    assign pop_is_data = i_pop_entry.kind == KIND_DATA;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_held_valid <= 1'b0;
            r_out_valid  <= 1'b0;
        end else begin
            if (r_out_valid && i_tready) begin
                r_out_valid <= 1'b0;
            end
            if (pop_fire) begin
                if (r_held_valid) begin
                    r_out_valid <= 1'b1;
                end
                // a close marker empties the holder, a data beat refills it
                r_held_valid <= pop_is_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_fire) begin
            if (r_held_valid) begin
                r_out_data <= r_held_data;
                // a new packet start or a done marker closes the held beat
                r_out_last <= pop_is_data ? i_pop_entry.first : 1'b1;
            end
            if (pop_is_data) begin
                r_held_data <= i_pop_entry.data;
            end
        end
    end

endmodule

//--- design/gem_dma_to_stream.sv
module gem_dma_to_stream import gem_pkg::*; #(
    parameter int ID_W        = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,

    // AXI4 write slave, driven by the MAC's DMA engine
    input  logic [ID_W-1:0] i_awid,
    input  gem_addr_u       i_awaddr,
    input  logic [7:0]      i_awlen,
    input  logic            i_awvalid,
    output logic            o_awready,

    input  data_t           i_wdata,
    input  logic            i_wlast,
    input  logic            i_wvalid,
    output logic            o_wready,

    output logic [ID_W-1:0] o_bid,
    output logic [1:0]      o_bresp,
    output logic            o_bvalid,
    input  logic            i_bready,

    // AXI-Stream master
    output data_t           o_tdata,
    output logic            o_tlast,
    output logic            o_tvalid,
    input  logic            i_tready
);

    logic   push_valid;
    entry_t push_entry;
    logic   push_ready;

    logic   pop_valid;
    entry_t pop_entry;
    logic   pop_ready;

    gem_write_slave #(
        .ID_W (ID_W)
    ) u_write_slave (
        .clk          (clk),
        .reset        (reset),
        .i_awid       (i_awid),
        .i_awaddr     (i_awaddr),
        .i_awlen      (i_awlen),
        .i_awvalid    (i_awvalid),
        .o_awready    (o_awready),
        .i_wdata      (i_wdata),
        .i_wlast      (i_wlast),
        .i_wvalid     (i_wvalid),
        .o_wready     (o_wready),
        .o_bid        (o_bid),
        .o_bresp      (o_bresp),
        .o_bvalid     (o_bvalid),
        .i_bready     (i_bready),
        .o_push_valid (push_valid),
        .o_push_entry (push_entry),
        .i_push_ready (push_ready)
    );

    // beats and close markers share one queue so they stay in order
    gem_beat_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_beat_queue (
        .clk          (clk),
        .reset        (reset),
        .i_push_valid (push_valid),
        .i_push_entry (push_entry),
        .o_push_ready (push_ready),
        .o_pop_valid  (pop_valid),
        .o_pop_entry  (pop_entry),
        .i_pop_ready  (pop_ready)
    );

    gem_tlast_stage u_tlast_stage (
        .clk         (clk),
        .reset       (reset),
        .i_pop_valid (pop_valid),
        .i_pop_entry (pop_entry),
        .o_pop_ready (pop_ready),
        .o_tdata     (o_tdata),
        .o_tlast     (o_tlast),
        .o_tvalid    (o_tvalid),
        .i_tready    (i_tready)
    );

endmodule

//--- bench/gem_asserts.sv
module gem_asserts import gem_pkg::*; (
    input logic  clk,
    input logic  reset,
    input data_t o_tdata,
    input logic  o_tlast,
    input logic  o_tvalid,
    input logic  i_tready,
    input logic  o_bvalid,
    input logic  i_bready
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled stream beat keeps its payload until taken
    stream_held: assert property (
        @(posedge clk) disable iff (reset)
        (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    ) else $error("stream beat changed while i_tready was low");

    // write response stays up until the master takes it
    bresp_held: assert property (
        @(posedge clk) disable iff (reset)
        (o_bvalid && !i_bready) |=> o_bvalid
    ) else $error("o_bvalid dropped before i_bready");

    // both valid outputs come out of reset low
    reset_quiet: assert property (
        @(posedge clk)
        reset |=> (!o_tvalid && !o_bvalid)
    ) else $error("o_tvalid or o_bvalid high right after reset");

endmodule

//--- bench/tb_gem_dma_to_stream.sv
module tb_gem_dma_to_stream import gem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         ID_W        = 2;
    localparam int         QUEUE_DEPTH = 4;
    localparam int         WAIT_LIMIT  = 200;
    localparam int         IDLE_CYCLES = 20;
    localparam string      TRACE_FILE  = "bench/gem_trace.txt";
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    logic            clk = 1'b0;
    logic            reset;
    logic [ID_W-1:0] i_awid;
    gem_addr_u       i_awaddr;
    logic [7:0]      i_awlen;
    logic            i_awvalid;
    logic            o_awready;
    data_t           i_wdata;
    logic            i_wlast;
    logic            i_wvalid;
    logic            o_wready;
    logic [ID_W-1:0] o_bid;
    logic [1:0]      o_bresp;
    logic            o_bvalid;
    logic            i_bready;
    data_t           o_tdata;
    logic            o_tlast;
    logic            o_tvalid;
    logic            i_tready = 1'b0;

    int   seed = 32'h3709;
    logic throttle = 1'b0;
    int   w_stalls;
    bit   verdict_given;

    // bursts and expected beats, filled from the trace
    logic [ID_W-1:0] burst_id_q[$];
    gem_addr_u       burst_addr_q[$];
    logic [7:0]      burst_len_q[$];
    data_t           wdata_q[$];
    data_t           exp_data_q[$];
    logic            exp_last_q[$];

    gem_dma_to_stream #(
        .ID_W        (ID_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_gem_dma_to_stream (
        .clk       (clk),
        .reset     (reset),
        .i_awid    (i_awid),
        .i_awaddr  (i_awaddr),
        .i_awlen   (i_awlen),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_wdata   (i_wdata),
        .i_wlast   (i_wlast),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .o_bid     (o_bid),
        .o_bresp   (o_bresp),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_tdata   (o_tdata),
        .o_tlast   (o_tlast),
        .o_tvalid  (o_tvalid),
        .i_tready  (i_tready)
    );

    bind gem_dma_to_stream gem_asserts u_gem_asserts (
        .clk      (clk),
        .reset    (reset),
        .o_tdata  (o_tdata),
        .o_tlast  (o_tlast),
        .o_tvalid (o_tvalid),
        .i_tready (i_tready),
        .o_bvalid (o_bvalid),
        .i_bready (i_bready)
    );

    always #2 clk = ~clk;

    // stream sink is mostly ready, and fully blocked while throttled
    always @(posedge clk) begin
        if (throttle) begin
            i_tready <= 1'b0;
        end else begin
            i_tready <= ($random(seed) & 32'h3) != 32'h0;
        end
    end

    task automatic stop_on_error(input string what);
        verdict_given = 1'b1;
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_beat(input int index, input data_t got_data, input logic got_last,
                              input data_t exp_data, input logic exp_last);
        if (got_data !== exp_data) begin
            stop_on_error($sformatf("Error at %0t: o_tdata of beat %0d is %h, expected %h",
                                    $time, index, got_data, exp_data));
        end
        if (got_last !== exp_last) begin
            stop_on_error($sformatf("Error at %0t: o_tlast of beat %0d is %b, expected %b",
                                    $time, index, got_last, exp_last));
        end
    endtask

    task automatic check_resp(input logic [ID_W-1:0] got_id, input logic [1:0] got_resp,
                              input logic [ID_W-1:0] exp_id);
        if (got_id !== exp_id) begin
            stop_on_error($sformatf("Error at %0t: o_bid is %h, expected %h",
                                    $time, got_id, exp_id));
        end
        if (got_resp !== RESP_OKAY) begin
            stop_on_error($sformatf("Error at %0t: o_bresp is %b, expected %b",
                                    $time, got_resp, RESP_OKAY));
        end
    endtask

    task automatic check_reset(input logic got_awready, input logic got_wready,
                               input logic got_bvalid, input logic got_tvalid);
        if (got_awready !== 1'b1) begin
            stop_on_error($sformatf("Error at %0t: o_awready is %b, expected 1",
                                    $time, got_awready));
        end
        if (got_wready !== 1'b0) begin
            stop_on_error($sformatf("Error at %0t: o_wready is %b, expected 0",
                                    $time, got_wready));
        end
        if (got_bvalid !== 1'b0) begin
            stop_on_error($sformatf("Error at %0t: o_bvalid is %b, expected 0",
                                    $time, got_bvalid));
        end
        if (got_tvalid !== 1'b0) begin
            stop_on_error($sformatf("Error at %0t: o_tvalid is %b, expected 0",
                                    $time, got_tvalid));
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          c;
        int          n;
        int          k;
        logic [31:0] id;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] word;
        logic [31:0] last;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            stop_on_error("could not open the trace file bench/gem_trace.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                // comment runs to the end of the line
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c == "W") begin
                n = $fscanf(fd, " %h %h %h", id, addr, len);
                if (n != 3) begin
                    stop_on_error("malformed burst line in the trace file");
                end
                burst_id_q.push_back(id[ID_W-1:0]);
                burst_addr_q.push_back(addr[ADDR_W-1:0]);
                burst_len_q.push_back(len[7:0]);
                for (k = 0; k <= int'(len[7:0]); k++) begin
                    n = $fscanf(fd, " %h", word);
                    if (n != 1) begin
                        stop_on_error("burst line in the trace file is short of data words");
                    end
                    wdata_q.push_back(word);
                end
            end else if (c == "E") begin
                n = $fscanf(fd, " %h %h", word, last);
                if (n != 2) begin
                    stop_on_error("malformed expect line in the trace file");
                end
                exp_data_q.push_back(word);
                exp_last_q.push_back(last[0]);
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                stop_on_error("unknown line type in the trace file");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // one AXI write burst: AW, every W beat, then the B response
    task automatic send_burst(input logic [ID_W-1:0] id, input gem_addr_u addr,
                              input logic [7:0] len);
        int    cycles;
        int    beat;
        int    burst_stalls;
        logic  seen;
        logic [ID_W-1:0] got_id;
        logic [1:0]      got_resp;
        burst_stalls = 0;
        // a long burst meets a blocked stream until the queue pushes back
        throttle  <= len > 8'd5;
        i_awid    <= id;
        i_awaddr  <= addr;
        i_awlen   <= len;
        i_awvalid <= 1'b1;
        seen = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
            @(negedge clk);
            seen = o_awready;
            @(posedge clk);
        end
        if (!seen) begin
            stop_on_error("timeout waiting for o_awready");
        end
        i_awvalid <= 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
            i_wdata  <= wdata_q.pop_front();
            i_wlast  <= beat == int'(len);
            i_wvalid <= 1'b1;
            seen = 1'b0;
            for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
                @(negedge clk);
                seen = o_wready;
                if (!seen) begin
                    w_stalls++;
                    burst_stalls++;
                end
                @(posedge clk);
                if (burst_stalls > 0) begin
                    throttle <= 1'b0;
                end
            end
            if (!seen) begin
                stop_on_error($sformatf("timeout waiting for o_wready on beat %0d", beat));
            end
        end
        i_wvalid <= 1'b0;
        i_wlast  <= 1'b0;
        throttle <= 1'b0;
        seen = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
            @(negedge clk);
            seen = o_bvalid;
            if (seen) begin
                got_id   = o_bid;
                got_resp = o_bresp;
            end
            @(posedge clk);
        end
        if (!seen) begin
            stop_on_error("timeout waiting for o_bvalid");
        end
        check_resp(got_id, got_resp, id);
        // the response waits a cycle before the master takes it
        i_bready <= 1'b1;
        @(posedge clk);
        i_bready <= 1'b0;
        @(negedge clk);
        if (o_bvalid !== 1'b0) begin
            stop_on_error("o_bvalid still high after its handshake, a second B response");
        end
        @(posedge clk);
    endtask

    task automatic drive_bursts();
        while (burst_id_q.size() > 0) begin
            send_burst(burst_id_q.pop_front(), burst_addr_q.pop_front(),
                       burst_len_q.pop_front());
        end
    endtask

    task automatic watch_stream();
        int    index;
        int    cycles;
        logic  seen;
        data_t got_data;
        logic  got_last;
        index = 0;
        while (exp_data_q.size() > 0) begin
            seen = 1'b0;
            for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
                @(negedge clk);
                seen = o_tvalid && i_tready;
                if (seen) begin
                    got_data = o_tdata;
                    got_last = o_tlast;
                end
                @(posedge clk);
            end
            if (!seen) begin
                stop_on_error($sformatf("timeout waiting for stream beat %0d", index));
            end
            check_beat(index, got_data, got_last, exp_data_q.pop_front(),
                       exp_last_q.pop_front());
            index++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        i_awid    = '0;
        i_awaddr  = '0;
        i_awlen   = '0;
        i_awvalid = 1'b0;
        i_wdata   = '0;
        i_wlast   = 1'b0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b0;
        w_stalls  = 0;
        verdict_given = 1'b0;
        load_trace();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_reset(o_awready, o_wready, o_bvalid, o_tvalid);
        @(posedge clk);
        fork
            drive_bursts();
            watch_stream();
        join
        // nothing may follow the last expected beat
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (o_tvalid !== 1'b0) begin
                stop_on_error("o_tvalid rose after every expected beat had been seen");
            end
        end
        if (w_stalls == 0) begin
            stop_on_error("the W channel never stalled, so the full queue was never reached");
        end else begin
            verdict_given = 1'b1;
            $display(">>> PASS");
            $finish;
        end
    end

    final begin
        if (!verdict_given) begin
            $display(">>> FAIL");
        end
    end

endmodule

//--- bench/gem_trace.txt
# W id addr awlen data... : one AXI write burst, awlen is beats minus one, all hex
# E data last             : next expected stream beat, data in hex, tlast 0 or 1
# packet A: two bursts from the data base, closed by a DMA-complete write
W 0 0000 3 a0000001 a0000002 a0000003 a0000004
W 1 0010 2 a0000005 a0000006 a0000007
W 2 1000 0 00000001
E a0000001 0
E a0000002 0
E a0000003 0
E a0000004 0
E a0000005 0
E a0000006 0
E a0000007 1
# packet B: closed only by the next burst at the data base
W 3 0000 1 b0000001 b0000002
W 0 0008 0 b0000003
# bit 0 clear, then the wrong register, neither one closes a packet
W 1 1000 0 00000002
W 2 1004 0 00000001
W 3 0000 2 c0000001 c0000002 c0000003
E b0000001 0
E b0000002 0
E b0000003 1
# packet C: continues after the gap, done word carries other bits too
W 0 000c 1 c0000004 c0000005
W 1 1000 0 ffffffff
E c0000001 0
E c0000002 0
E c0000003 0
E c0000004 0
E c0000005 1
# done with nothing held is dropped
W 2 1000 0 00000001
# packet D: long burst into a blocked stream, then single-beat packet E
W 3 0000 7 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007 d0000008
W 0 0000 0 e0000001
W 1 1000 0 00000001
E d0000001 0
E d0000002 0
E d0000003 0
E d0000004 0
E d0000005 0
E d0000006 0
E d0000007 0
E d0000008 1
E e0000001 1

//--- sim.f
design/gem_pkg.sv
design/gem_write_slave.sv
design/gem_beat_queue.sv
design/gem_tlast_stage.sv
design/gem_dma_to_stream.sv
bench/gem_asserts.sv
bench/tb_gem_dma_to_stream.sv

//--- Makefile
TOP = tb_gem_dma_to_stream

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
